//--- hw/mmio_pkg.sv
// Address map, bus widths, request queue sizing, CSR word layout and the queued request type
`default_nettype none

package mmio_pkg;

    // ==================================================
    // Bus widths
    // ==================================================

    // One MMIO beat carries a full 512-bit line
    localparam int mmio_data_w = 512;
    localparam int mmio_be_w   = mmio_data_w / 8;

    // A line address spans 128 lines and only some of them are backed by storage
    localparam int mmio_addr_w = 7;

    // ==================================================
    // Address map
    // ==================================================

    // CSR line sits at the bottom of the space
    localparam logic [mmio_addr_w-1:0] csr_line_addr = 7'd0;

    // Scratch memory fills the upper half, so its index is the low address bits
    localparam logic [mmio_addr_w-1:0] ram_base_addr = 7'd64;
    localparam int ram_depth = 64;
    localparam int ram_idx_w = $clog2(ram_depth);

    // Request queue sizing
    localparam int req_fifo_depth = 4;
    localparam int fifo_ptr_w     = $clog2(req_fifo_depth);
    localparam int fifo_cnt_w     = $clog2(req_fifo_depth + 1);

    // ==================================================
    // CSR line layout
    // ==================================================

    // The CSR line is split into 64-bit words
    localparam int csr_word_w = 64;
    localparam int csr_words  = mmio_data_w / csr_word_w;

    // Identifier returned in word 0
    localparam logic [csr_word_w-1:0] afu_id = 64'h6d6d_696f_0a1f_3c5e;

    localparam int csr_word_id       = 0;
    localparam int csr_word_scratch0 = 1;
    localparam int csr_word_scratch1 = 2;
    localparam int csr_word_scratch2 = 3;
    localparam int csr_word_scratch3 = 4;
    localparam int csr_word_wr_count = 5;
    localparam int csr_scratch_n     = 4;

    // One host request as it sits in the queue
    typedef struct packed {
        logic                   is_write;
        logic [mmio_addr_w-1:0] address;
        logic [mmio_data_w-1:0] writedata;
        logic [mmio_be_w-1:0]   byteenable;
    } mmio_req_t;

endpackage

`default_nettype wire

//--- hw/avalon_mmio_if.sv
// Avalon-style request and response bundle between the decoder and one peer block
`timescale 1ns/100ps
`default_nettype none

interface avalon_mmio_if import mmio_pkg::*; #(
    // Peers that only need a local index get a narrower address
    parameter int addr_w = mmio_addr_w
) ();

    // Request side, driven by the decoder
    logic [addr_w-1:0]      address;
    logic                   read;
    logic                   write;
    logic [mmio_data_w-1:0] writedata;
    logic [mmio_be_w-1:0]   byteenable;

    // Response side, driven by the peer one cycle after a read
    logic [mmio_data_w-1:0] readdata;
    logic                   readdatavalid;

    // The peer end
    modport target (
        input  address, read, write, writedata, byteenable,
        output readdata, readdatavalid
    );

    // The decoder end
    modport source (
        output address, read, write, writedata, byteenable,
        input  readdata, readdatavalid
    );

endinterface

`default_nettype wire

//--- hw/mmio_req_fifo.sv
// Host request queue with full flag as waitrequest and a pop handshake toward the decoder
`timescale 1ns/100ps
`default_nettype none

module mmio_req_fifo import mmio_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [mmio_addr_w-1:0] address,
    input  logic                   read,
    input  logic                   write,
    input  logic [mmio_data_w-1:0] writedata,
    input  logic [mmio_be_w-1:0]   byteenable,
    output logic                   waitrequest,
    output mmio_req_t              req,
    output logic                   req_valid,
    input  logic                   req_pop
);

    // Circular buffer storage for the queued requests
    mmio_req_t entries [req_fifo_depth];

    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0] count;
    logic                  full;
    logic                  push;
    logic                  pop;

    assign full = (count == fifo_cnt_w'(req_fifo_depth));

    // Host sees the full flag directly as waitrequest
    assign waitrequest = full;

    // Accept in any cycle with a strobe and no stall
    assign push = (read || write) && !waitrequest;
    assign pop  = req_valid && req_pop;

    // Head of queue is always presented to the decoder
    assign req_valid = (count != '0);
    assign req       = entries[rd_ptr];

    // Store the accepted request at the write pointer, which wraps at a power-of-two depth
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr].is_write   <= write;
            entries[wr_ptr].address    <= address;
            entries[wr_ptr].writedata  <= writedata;
            entries[wr_ptr].byteenable <= byteenable;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Avalon allows only one strobe per request
    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(read && write));

    // A full queue takes no further entry, so occupancy stays in range and matches the pointers
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        full |=> (count <= fifo_cnt_w'(req_fifo_depth))
              && (fifo_ptr_w'(count) == fifo_ptr_w'(wr_ptr - rd_ptr)));

endmodule

`default_nettype wire

//--- hw/mmio_region_decoder.sv
// Region decoder that drains the request queue, routes to the CSR and RAM peers, and merges read data
`timescale 1ns/100ps
`default_nettype none

module mmio_region_decoder import mmio_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  mmio_req_t              req,
    input  logic                   req_valid,
    output logic                   req_pop,
    avalon_mmio_if.source          csr_bus,
    avalon_mmio_if.source          ram_bus,
    output logic [mmio_data_w-1:0] readdata,
    output logic                   readdatavalid
);

    logic hit_csr;
    logic hit_ram;
    logic hit_hole;
    logic is_rd;
    logic is_wr;
    // Read to the unused hole, answered with zeros a cycle later
    logic pend_zero;

    // ==================================================
    // Request side
    // ==================================================

    // Peers never stall, so every valid request is taken at once
    assign req_pop = req_valid;

    assign is_rd = req_valid && !req.is_write;
    assign is_wr = req_valid && req.is_write;

    // Three-way split of the line address
    assign hit_csr  = (req.address == csr_line_addr);
    assign hit_ram  = (req.address >= ram_base_addr);
    assign hit_hole = !hit_csr && !hit_ram;

    // CSR bank sees the full line address
    assign csr_bus.address    = req.address;
    assign csr_bus.writedata  = req.writedata;
    assign csr_bus.byteenable = req.byteenable;
    assign csr_bus.read       = is_rd && hit_csr;
    assign csr_bus.write      = is_wr && hit_csr;

    // Memory only gets its local index
    assign ram_bus.address    = req.address[ram_idx_w-1:0];
    assign ram_bus.writedata  = req.writedata;
    assign ram_bus.byteenable = req.byteenable;
    assign ram_bus.read       = is_rd && hit_ram;
    assign ram_bus.write      = is_wr && hit_ram;

    // Writes into the hole reach no peer and are dropped here
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_zero <= 1'b0;
        end else begin
            pend_zero <= is_rd && hit_hole;
        end
    end

    // ==================================================
    // Response side
    // ==================================================

    // Only one source can answer in a cycle since one request is issued per cycle
    assign readdatavalid = csr_bus.readdatavalid || ram_bus.readdatavalid || pend_zero;

    always_comb begin
        if (csr_bus.readdatavalid) begin
            readdata = csr_bus.readdata;
        end else if (ram_bus.readdatavalid) begin
            readdata = ram_bus.readdata;
        end else begin
            // hole reads and idle cycles return zero
            readdata = '0;
        end
    end

    // Responses from the peers and the hole never collide
    a_one_source: assert property (@(posedge clk) disable iff (rst)
        $onehot0({csr_bus.readdatavalid, ram_bus.readdatavalid, pend_zero}));

endmodule

`default_nettype wire

//--- hw/afu_csr_bank.sv
// CSR line with identifier word, four byte-writable scratch registers and a write counter
`timescale 1ns/100ps
`default_nettype none

module afu_csr_bank import mmio_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    avalon_mmio_if.target bus
);

    logic [csr_word_w-1:0]  scratch [csr_scratch_n];
    logic [csr_word_w-1:0]  wr_count;
    logic [mmio_data_w-1:0] line;
    logic [mmio_data_w-1:0] rdata_q;
    logic                   rdv_q;

    // ==================================================
    // Register updates
    // ==================================================

    // Scratch words take only the bytes enabled in their slice of the line
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < csr_scratch_n; i++) begin
                scratch[i] <= '0;
            end
            wr_count <= '0;
        end else if (bus.write) begin
            for (int i = 0; i < csr_scratch_n; i++) begin
                for (int b = 0; b < csr_word_w / 8; b++) begin
                    if (bus.byteenable[(csr_word_scratch0 + i) * (csr_word_w / 8) + b]) begin
                        scratch[i][b*8 +: 8] <=
                            bus.writedata[(csr_word_scratch0 + i) * csr_word_w + b*8 +: 8];
                    end
                end
            end
            // Every write is counted, even one with no bytes enabled
            wr_count <= wr_count + 1'b1;
        end
    end

    // ==================================================
    // Read path
    // ==================================================

    // Assemble the whole line with the unused words held at zero
    always_comb begin
        line = '0;
        line[csr_word_id       * csr_word_w +: csr_word_w] = afu_id;
        line[csr_word_scratch0 * csr_word_w +: csr_word_w] = scratch[0];
        line[csr_word_scratch1 * csr_word_w +: csr_word_w] = scratch[1];
        line[csr_word_scratch2 * csr_word_w +: csr_word_w] = scratch[2];
        line[csr_word_scratch3 * csr_word_w +: csr_word_w] = scratch[3];
        line[csr_word_wr_count * csr_word_w +: csr_word_w] = wr_count;
    end

    // The read register captures the assembled line on a read strobe
    always_ff @(posedge clk) begin
        if (bus.read) begin
            rdata_q <= line;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdv_q <= 1'b0;
        end else begin
            rdv_q <= bus.read;
        end
    end

    assign bus.readdata      = rdata_q;
    assign bus.readdatavalid = rdv_q;

    // Every returned line carries the identifier in word 0 and zeros above the counter
    a_line_layout: assert property (@(posedge clk) disable iff (rst)
        bus.readdatavalid |->
            (bus.readdata[csr_word_id * csr_word_w +: csr_word_w] == afu_id)
            && (bus.readdata[mmio_data_w-1:(csr_word_wr_count + 1) * csr_word_w] == '0));

    // The decoder must only route the CSR line here
    a_csr_addr: assert property (@(posedge clk) disable iff (rst)
        (bus.read || bus.write) |-> (bus.address == csr_line_addr));

endmodule

`default_nettype wire

//--- hw/scratch_line_ram.sv
// Scratch memory of 512-bit lines with byte enables and a registered one-cycle read
`timescale 1ns/100ps
`default_nettype none

module scratch_line_ram import mmio_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    avalon_mmio_if.target bus
);

    // Contents are undefined after reset
    logic [mmio_data_w-1:0] mem [ram_depth];
    logic [mmio_data_w-1:0] rdata_q;
    logic                   rdv_q;

    // Byte-enabled line write
    always_ff @(posedge clk) begin
        if (bus.write) begin
            for (int b = 0; b < mmio_be_w; b++) begin
                if (bus.byteenable[b]) begin
                    mem[bus.address][b*8 +: 8] <= bus.writedata[b*8 +: 8];
                end
            end
        end
    end

    // Read register loads only on a read strobe
    always_ff @(posedge clk) begin
        if (bus.read) begin
            rdata_q <= mem[bus.address];
        end
    end

    // Valid pulse follows the read strobe by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rdv_q <= 1'b0;
        end else begin
            rdv_q <= bus.read;
        end
    end

    assign bus.readdata      = rdata_q;
    assign bus.readdatavalid = rdv_q;

    // The decoder issues one request per cycle so read and write never meet here
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(bus.read && bus.write));

endmodule

`default_nettype wire

//--- hw/mmio_afu_top.sv
// Top level of the MMIO function unit wiring the request queue, region decoder, CSR bank and RAM
`timescale 1ns/100ps
`default_nettype none

module mmio_afu_top import mmio_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [mmio_addr_w-1:0] address,
    input  logic                   read,
    input  logic                   write,
    input  logic [mmio_data_w-1:0] writedata,
    input  logic [mmio_be_w-1:0]   byteenable,
    output logic                   waitrequest,
    output logic [mmio_data_w-1:0] readdata,
    output logic                   readdatavalid
);

    // ==================================================
    // Request queue to decoder
    // ==================================================

    mmio_req_t req;
    logic      req_valid;
    logic      req_pop;

    mmio_req_fifo u_req_fifo (
        .clk         (clk),
        .rst         (rst),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .req         (req),
        .req_valid   (req_valid),
        .req_pop     (req_pop)
    );

    // ==================================================
    // Decoder and peers
    // ==================================================

    // The CSR path keeps the full address while the RAM path carries only its index
    avalon_mmio_if #(.addr_w(mmio_addr_w)) csr_bus ();
    avalon_mmio_if #(.addr_w(ram_idx_w))   ram_bus ();

    mmio_region_decoder u_decoder (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .req_valid     (req_valid),
        .req_pop       (req_pop),
        .csr_bus       (csr_bus.source),
        .ram_bus       (ram_bus.source),
        .readdata      (readdata),
        .readdatavalid (readdatavalid)
    );

    afu_csr_bank u_csr_bank (
        .clk (clk),
        .rst (rst),
        .bus (csr_bus.target)
    );

    scratch_line_ram u_scratch_ram (
        .clk (clk),
        .rst (rst),
        .bus (ram_bus.target)
    );

endmodule

`default_nettype wire

//--- tb/tb_mmio_afu.sv
// Testbench for mmio_afu_top with clock, stimulus, reference model, comparator and watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_mmio_afu import mmio_pkg::*; ();

    // ==================================================
    // Test sizing
    // ==================================================

    localparam int clk_period = 40;
    localparam int n_csr_wr   = 12;
    localparam int n_partial  = 40;
    localparam int n_hole     = 16;
    localparam int n_recheck  = 8;
    localparam int n_mix      = 10;
    // Every request issued by the sequence below, used to size the watchdog
    localparam int total_reqs = 1 + 2 * n_csr_wr + 2 * ram_depth + n_partial
                              + 2 * n_hole + 1 + n_recheck + 3 * n_mix;

    logic                   clk;
    logic                   rst;
    logic [mmio_addr_w-1:0] address;
    logic                   read;
    logic                   write;
    logic [mmio_data_w-1:0] writedata;
    logic [mmio_be_w-1:0]   byteenable;
    logic                   waitrequest;
    logic [mmio_data_w-1:0] readdata;
    logic                   readdatavalid;

    // Shadow state of the DUT
    logic [mmio_data_w-1:0] shadow_mem [ram_depth];
    logic [csr_word_w-1:0]  shadow_scratch [csr_scratch_n];
    logic [csr_word_w-1:0]  shadow_wr_count;

    // Expected responses in acceptance order, with the cycle each was accepted in
    logic [mmio_data_w-1:0] exp_data [$];
    int                     exp_cycle [$];
    logic [mmio_data_w-1:0] exp_line;
    int                     exp_cyc;
    int                     cycle_cnt = 0;
    int                     order [ram_depth];
    int                     swap_idx;
    int                     tmp;

    mmio_afu_top uut (
        .clk           (clk),
        .rst           (rst),
        .address       (address),
        .read          (read),
        .write         (write),
        .writedata     (writedata),
        .byteenable    (byteenable),
        .waitrequest   (waitrequest),
        .readdata      (readdata),
        .readdatavalid (readdatavalid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Cycle index of the most recent rising edge
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ==================================================
    // Reference model and checking
    // ==================================================

    function automatic logic [mmio_data_w-1:0] model_read(input logic [mmio_addr_w-1:0] addr);
        logic [mmio_data_w-1:0] line;
        line = '0;
        if (addr == csr_line_addr) begin
            line[63:0] = afu_id;
            for (int i = 0; i < csr_scratch_n; i++) begin
                line[(i + 1) * 64 +: 64] = shadow_scratch[i];
            end
            line[5 * 64 +: 64] = shadow_wr_count;
        end else if (addr >= ram_base_addr) begin
            line = shadow_mem[addr - ram_base_addr];
        end
        // Lines in the hole stay zero
        return line;
    endfunction

    task automatic model_write(input logic [mmio_addr_w-1:0] addr,
                               input logic [mmio_data_w-1:0] data,
                               input logic [mmio_be_w-1:0]   be);
        if (addr == csr_line_addr) begin
            // Scratch words are line words 1 to 4, bytes 8 to 39
            for (int b = 8; b < 40; b++) begin
                if (be[b]) begin
                    shadow_scratch[b / 8 - 1][(b % 8) * 8 +: 8] = data[b * 8 +: 8];
                end
            end
            shadow_wr_count = shadow_wr_count + 1;
        end else if (addr >= ram_base_addr) begin
            for (int b = 0; b < mmio_be_w; b++) begin
                if (be[b]) begin
                    shadow_mem[addr - ram_base_addr][b * 8 +: 8] = data[b * 8 +: 8];
                end
            end
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [mmio_data_w-1:0] got,
                               input logic [mmio_data_w-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s got %0h expected %0h", $time, name, got, exp);
            abort_run("Mismatch on DUT output");
        end
    endtask

    // Outputs sampled mid-cycle where they are stable
    always @(negedge clk) begin
        // The decoder drains one request per cycle, so the queue never fills
        check_value("waitrequest", waitrequest, '0);
        if (rst) begin
            check_value("readdatavalid", readdatavalid, '0);
        end else if (readdatavalid) begin
            if (exp_data.size() == 0) begin
                abort_run("Unexpected read data, readdatavalid with no read outstanding");
            end else begin
                exp_line = exp_data.pop_front();
                exp_cyc  = exp_cycle.pop_front();
                check_value("readdata", readdata, exp_line);
                // The next edge is the one that samples this response
                check_value("readdatavalid_cycle", cycle_cnt + 1, exp_cyc + 2);
            end
        end
    end

    initial begin
        repeat (total_reqs * 4 + 200) @(posedge clk);
        abort_run("Timeout, the run did not finish in time");
    end

    // ==================================================
    // Stimulus
    // ==================================================

    function automatic logic [mmio_data_w-1:0] rand_line();
        logic [mmio_data_w-1:0] v;
        for (int i = 0; i < mmio_data_w / 32; i++) begin
            v[i * 32 +: 32] = $urandom;
        end
        return v;
    endfunction

    function automatic logic [mmio_be_w-1:0] rand_be();
        return {$urandom, $urandom};
    endfunction

    // Holds the request until waitrequest is low, then updates the model at acceptance
    task automatic issue(input logic is_wr, input logic [mmio_addr_w-1:0] addr,
                         input logic [mmio_data_w-1:0] data, input logic [mmio_be_w-1:0] be);
        @(posedge clk);
        #2;
        address    = addr;
        read       = !is_wr;
        write      = is_wr;
        writedata  = data;
        byteenable = be;
        while (waitrequest) begin
            @(posedge clk);
            #2;
        end
        if (is_wr) begin
            model_write(addr, data, be);
        end else begin
            exp_data.push_back(model_read(addr));
            exp_cycle.push_back(cycle_cnt + 1);
        end
    endtask

    task automatic read_line(input logic [mmio_addr_w-1:0] addr);
        issue(1'b0, addr, '0, '0);
    endtask

    task automatic write_line(input logic [mmio_addr_w-1:0] addr,
                              input logic [mmio_data_w-1:0] data,
                              input logic [mmio_be_w-1:0]   be);
        issue(1'b1, addr, data, be);
    endtask

    function automatic logic [mmio_addr_w-1:0] rand_ram_addr();
        return ram_base_addr + mmio_addr_w'($urandom % ram_depth);
    endfunction

    function automatic logic [mmio_addr_w-1:0] rand_hole_addr();
        return mmio_addr_w'(1 + $urandom % 63);
    endfunction

    initial begin
        void'($urandom(32'h80c9));
        rst        = 1'b1;
        address    = '0;
        read       = 1'b0;
        write      = 1'b0;
        writedata  = '0;
        byteenable = '0;
        for (int i = 0; i < csr_scratch_n; i++) begin
            shadow_scratch[i] = '0;
        end
        shadow_wr_count = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        // Identifier and cleared registers after reset
        read_line(csr_line_addr);

        // Scratch registers under random byte enables, each followed by a readback
        for (int i = 0; i < n_csr_wr; i++) begin
            write_line(csr_line_addr, rand_line(), rand_be());
            read_line(csr_line_addr);
        end

        // Every memory line is fully written first so no byte stays undefined
        for (int i = 0; i < ram_depth; i++) begin
            write_line(ram_base_addr + mmio_addr_w'(i), rand_line(), '1);
        end
        for (int i = 0; i < n_partial; i++) begin
            write_line(rand_ram_addr(), rand_line(), rand_be());
        end
        // Shuffled read order over all lines
        for (int i = 0; i < ram_depth; i++) begin
            order[i] = i;
        end
        for (int i = ram_depth - 1; i > 0; i--) begin
            swap_idx        = $urandom % (i + 1);
            tmp             = order[i];
            order[i]        = order[swap_idx];
            order[swap_idx] = tmp;
        end
        for (int i = 0; i < ram_depth; i++) begin
            read_line(ram_base_addr + mmio_addr_w'(order[i]));
        end

        // Hole reads return zero and hole writes must not disturb anything
        for (int i = 0; i < n_hole; i++) begin
            read_line(rand_hole_addr());
        end
        for (int i = 0; i < n_hole; i++) begin
            write_line(rand_hole_addr(), rand_line(), '1);
        end
        read_line(csr_line_addr);
        for (int i = 0; i < n_recheck; i++) begin
            read_line(rand_ram_addr());
        end

        // Back-to-back mix of all three regions
        for (int i = 0; i < n_mix; i++) begin
            read_line(csr_line_addr);
            read_line(rand_ram_addr());
            read_line(rand_hole_addr());
        end

        @(posedge clk);
        #2;
        read  = 1'b0;
        write = 1'b0;
        // Wait past the two-cycle read latency of the last request
        repeat (4) @(posedge clk);
        if (exp_data.size() != 0) begin
            $display("Missing responses, %0d reads never returned data", exp_data.size());
            abort_run("Read responses were lost");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- list.f
hw/mmio_pkg.sv
hw/avalon_mmio_if.sv
hw/mmio_req_fifo.sv
hw/mmio_region_decoder.sv
hw/afu_csr_bank.sv
hw/scratch_line_ram.sv
hw/mmio_afu_top.sv
tb/tb_mmio_afu.sv

//--- Bender.yml
package:
  name: mmio_afu

sources:
  # Package first, then the interface, then modules below the top
  - hw/mmio_pkg.sv
  - hw/avalon_mmio_if.sv
  - hw/mmio_req_fifo.sv
  - hw/mmio_region_decoder.sv
  - hw/afu_csr_bank.sv
  - hw/scratch_line_ram.sv
  - hw/mmio_afu_top.sv

  # Testbench, only for simulation
  - target: test
    files:
      - tb/tb_mmio_afu.sv
